// File: common/exu_macros.svh
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// ============================================================
// Datapath and register file
// ============================================================
`define EXU_DATA_W     32
`define EXU_NREGS      32
`define EXU_REG_W      5

// ============================================================
// Execution units
// ============================================================
// Depth of the multiply pipe, equal to its latency
`define EXU_MUL_STAGES 5

// Low bits of rs2 used by the shift
`define EXU_SHAMT_W    5

`endif

// File: common/exu_pkg.sv
`default_nettype none

`include "exu_macros.svh"

package exu_pkg;

  // Operand, result or immediate
  typedef logic [`EXU_DATA_W-1:0] data_t;

  // Architectural register index
  typedef logic [`EXU_REG_W-1:0] reg_idx_t;

  // Opcodes of the back end
  typedef enum logic [2:0] {
    OP_LI  = 3'd0,
    OP_ADD = 3'd1,
    OP_SUB = 3'd2,
    OP_AND = 3'd3,
    OP_OR  = 3'd4,
    OP_XOR = 3'd5,
    OP_SLL = 3'd6,
    OP_MUL = 3'd7
  } op_e;

endpackage

`default_nettype wire

// File: design/issue_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_macros.svh"

module issue_ctrl (
  input  logic              clk_i,
  input  logic              rst_i,

  input  logic              issue_valid_i,
  output logic              issue_ready_o,
  input  exu_pkg::op_e      issue_op_i,
  input  exu_pkg::reg_idx_t issue_rd_i,
  input  exu_pkg::reg_idx_t issue_rs1_i,
  input  exu_pkg::reg_idx_t issue_rs2_i,
  input  exu_pkg::data_t    issue_imm_i,

  input  exu_pkg::data_t    rs1_data_i,
  input  exu_pkg::data_t    rs2_data_i,

  input  logic              mul_stage4_busy_i,

  input  logic              clr_valid_i,
  input  exu_pkg::reg_idx_t clr_rd_i,

  output logic              alu_start_o,
  output logic              mul_start_o,
  output exu_pkg::op_e      ex_op_o,
  output exu_pkg::reg_idx_t ex_rd_o,
  output exu_pkg::data_t    ex_a_o,
  output exu_pkg::data_t    ex_b_o
);

  logic [`EXU_NREGS-1:0] pending_q;
  logic [`EXU_NREGS-1:0] set_mask;
  logic [`EXU_NREGS-1:0] clr_mask;
  logic                  is_mul;
  logic                  uses_src;
  logic                  src_hazard;
  logic                  dst_hazard;
  logic                  wb_conflict;
  logic                  accept;

  // ============================================================
  // Hazard check
  // ============================================================
  assign is_mul   = (issue_op_i == exu_pkg::OP_MUL);
  assign uses_src = (issue_op_i != exu_pkg::OP_LI);

  // r0 is never pending, so its reads never stall
  assign src_hazard  = uses_src && (pending_q[issue_rs1_i] || pending_q[issue_rs2_i]);
  assign dst_hazard  = pending_q[issue_rd_i];

  // ALU result would meet the multiply leaving stage five
  assign wb_conflict = !is_mul && mul_stage4_busy_i;

  assign issue_ready_o = !(src_hazard || dst_hazard || wb_conflict);
  assign accept        = issue_valid_i && issue_ready_o;

  // ============================================================
  // Dispatch
  // ============================================================
  assign alu_start_o = accept && !is_mul;
  assign mul_start_o = accept && is_mul;
  assign ex_op_o     = issue_op_i;
  assign ex_rd_o     = issue_rd_i;
  assign ex_a_o      = uses_src ? rs1_data_i : issue_imm_i;
  assign ex_b_o      = rs2_data_i;

  // Scoreboard update
  always_comb begin
    set_mask = '0;
    clr_mask = '0;
    if (accept && (issue_rd_i != '0)) begin
      set_mask[issue_rd_i] = 1'b1;
    end
    if (clr_valid_i) begin
      clr_mask[clr_rd_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~clr_mask) | set_mask;
    end
  end

  // A register being written back is never claimed again in that cycle
  a_no_set_clr: assert property (@(posedge clk_i) disable iff (!rst_i)
    (set_mask & clr_mask) == '0);

endmodule

`default_nettype wire

// File: design/reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_macros.svh"

module reg_bank (
  input  logic              clk_i,
  input  logic              rst_i,

  input  exu_pkg::reg_idx_t rd_a_i,
  input  exu_pkg::reg_idx_t rd_b_i,
  output exu_pkg::data_t    rd_a_data_o,
  output exu_pkg::data_t    rd_b_data_o,

  input  logic              wr_en_i,
  input  exu_pkg::reg_idx_t wr_idx_i,
  input  exu_pkg::data_t    wr_data_i
);

  exu_pkg::data_t regs_q [`EXU_NREGS];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < `EXU_NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && (wr_idx_i != '0)) begin
      regs_q[wr_idx_i] <= wr_data_i;
    end
  end

  // Hardwired zero register, no write bypass
  assign rd_a_data_o = (rd_a_i == '0) ? '0 : regs_q[rd_a_i];
  assign rd_b_data_o = (rd_b_i == '0) ? '0 : regs_q[rd_b_i];

endmodule

`default_nettype wire

// File: exec/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_macros.svh"

module alu_unit (
  input  logic              clk_i,
  input  logic              rst_i,

  input  logic              start_i,
  input  exu_pkg::op_e      op_i,
  input  exu_pkg::reg_idx_t rd_i,
  input  exu_pkg::data_t    a_i,
  input  exu_pkg::data_t    b_i,

  output logic              res_valid_o,
  output exu_pkg::reg_idx_t res_rd_o,
  output exu_pkg::data_t    res_data_o
);

  exu_pkg::data_t result;

  // ============================================================
  // Single-cycle operations
  // ============================================================
  always_comb begin
    case (op_i)
      exu_pkg::OP_LI:  result = a_i;
      exu_pkg::OP_ADD: result = a_i + b_i;
      exu_pkg::OP_SUB: result = a_i - b_i;
      exu_pkg::OP_AND: result = a_i & b_i;
      exu_pkg::OP_OR:  result = a_i | b_i;
      exu_pkg::OP_XOR: result = a_i ^ b_i;
      exu_pkg::OP_SLL: result = a_i << b_i[`EXU_SHAMT_W-1:0];
      default:         result = '0;
    endcase
  end

  // Result register
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= start_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      res_rd_o   <= rd_i;
      res_data_o <= result;
    end
  end

  // Multiplies are routed to the multiply pipe only
  a_no_mul: assert property (@(posedge clk_i) disable iff (!rst_i)
    start_i |-> (op_i != exu_pkg::OP_MUL));

endmodule

`default_nettype wire

// File: exec/mul_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_macros.svh"

module mul_pipe (
  input  logic              clk_i,
  input  logic              rst_i,

  input  logic              start_i,
  input  exu_pkg::reg_idx_t rd_i,
  input  exu_pkg::data_t    a_i,
  input  exu_pkg::data_t    b_i,

  output logic              stage4_busy_o,

  output logic              res_valid_o,
  output exu_pkg::reg_idx_t res_rd_o,
  output exu_pkg::data_t    res_data_o
);

  // Stage one holds the operands
  logic              s1_valid_q;
  exu_pkg::reg_idx_t s1_rd_q;
  exu_pkg::data_t    s1_a_q;
  exu_pkg::data_t    s1_b_q;

  // Stages two to five carry the low half of the product
  logic              val_q  [2:`EXU_MUL_STAGES];
  exu_pkg::reg_idx_t rd_q   [2:`EXU_MUL_STAGES];
  exu_pkg::data_t    data_q [2:`EXU_MUL_STAGES];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      s1_valid_q <= 1'b0;
      for (int k = 2; k <= `EXU_MUL_STAGES; k++) begin
        val_q[k] <= 1'b0;
      end
    end else begin
      s1_valid_q <= start_i;
      val_q[2]   <= s1_valid_q;
      for (int k = 3; k <= `EXU_MUL_STAGES; k++) begin
        val_q[k] <= val_q[k-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      s1_rd_q <= rd_i;
      s1_a_q  <= a_i;
      s1_b_q  <= b_i;
    end
    rd_q[2]   <= s1_rd_q;
    data_q[2] <= s1_a_q * s1_b_q;
    for (int k = 3; k <= `EXU_MUL_STAGES; k++) begin
      rd_q[k]   <= rd_q[k-1];
      data_q[k] <= data_q[k-1];
    end
  end

  // Stage four leaves for writeback on the next edge
  assign stage4_busy_o = val_q[`EXU_MUL_STAGES-1];

  assign res_valid_o = val_q[`EXU_MUL_STAGES];
  assign res_rd_o    = rd_q[`EXU_MUL_STAGES];
  assign res_data_o  = data_q[`EXU_MUL_STAGES];

endmodule

`default_nettype wire

// File: design/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
  input  logic              clk_i,

  input  logic              alu_valid_i,
  input  exu_pkg::reg_idx_t alu_rd_i,
  input  exu_pkg::data_t    alu_data_i,

  input  logic              mul_valid_i,
  input  exu_pkg::reg_idx_t mul_rd_i,
  input  exu_pkg::data_t    mul_data_i,

  output logic              wr_en_o,
  output exu_pkg::reg_idx_t wr_idx_o,
  output exu_pkg::data_t    wr_data_o,

  output logic              wb_valid_o,
  output exu_pkg::reg_idx_t wb_rd_o,
  output exu_pkg::data_t    wb_data_o
);

  logic              any_valid;
  exu_pkg::reg_idx_t sel_rd;
  exu_pkg::data_t    sel_data;

  // Issue keeps the two sources apart, so a plain select is enough
  assign any_valid = alu_valid_i || mul_valid_i;
  assign sel_rd    = alu_valid_i ? alu_rd_i   : mul_rd_i;
  assign sel_data  = alu_valid_i ? alu_data_i : mul_data_i;

  // Writes to r0 are dropped
  assign wr_en_o   = any_valid && (sel_rd != '0);
  assign wr_idx_o  = sel_rd;
  assign wr_data_o = sel_data;

  assign wb_valid_o = wr_en_o;
  assign wb_rd_o    = sel_rd;
  assign wb_data_o  = sel_data;

  a_one_source: assert property (@(posedge clk_i)
    (alu_valid_i & mul_valid_i) !== 1'b1);

endmodule

`default_nettype wire

// File: design/exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module exu_top (
  input  logic              clk_i,
  input  logic              rst_i,

  input  logic              issue_valid_i,
  output logic              issue_ready_o,
  input  exu_pkg::op_e      issue_op_i,
  input  exu_pkg::reg_idx_t issue_rd_i,
  input  exu_pkg::reg_idx_t issue_rs1_i,
  input  exu_pkg::reg_idx_t issue_rs2_i,
  input  exu_pkg::data_t    issue_imm_i,

  output logic              wb_valid_o,
  output exu_pkg::reg_idx_t wb_rd_o,
  output exu_pkg::data_t    wb_data_o
);

  // Operands
  exu_pkg::data_t    rs1_data;
  exu_pkg::data_t    rs2_data;

  // Dispatch
  logic              alu_start;
  logic              mul_start;
  exu_pkg::op_e      ex_op;
  exu_pkg::reg_idx_t ex_rd;
  exu_pkg::data_t    ex_a;
  exu_pkg::data_t    ex_b;
  logic              mul_stage4_busy;

  // Results
  logic              alu_res_valid;
  exu_pkg::reg_idx_t alu_res_rd;
  exu_pkg::data_t    alu_res_data;
  logic              mul_res_valid;
  exu_pkg::reg_idx_t mul_res_rd;
  exu_pkg::data_t    mul_res_data;

  // Register write, also the scoreboard clear
  logic              wr_en;
  exu_pkg::reg_idx_t wr_idx;
  exu_pkg::data_t    wr_data;

  issue_ctrl u_issue (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .issue_valid_i     (issue_valid_i),
    .issue_ready_o     (issue_ready_o),
    .issue_op_i        (issue_op_i),
    .issue_rd_i        (issue_rd_i),
    .issue_rs1_i       (issue_rs1_i),
    .issue_rs2_i       (issue_rs2_i),
    .issue_imm_i       (issue_imm_i),
    .rs1_data_i        (rs1_data),
    .rs2_data_i        (rs2_data),
    .mul_stage4_busy_i (mul_stage4_busy),
    .clr_valid_i       (wr_en),
    .clr_rd_i          (wr_idx),
    .alu_start_o       (alu_start),
    .mul_start_o       (mul_start),
    .ex_op_o           (ex_op),
    .ex_rd_o           (ex_rd),
    .ex_a_o            (ex_a),
    .ex_b_o            (ex_b)
  );

  reg_bank u_regs (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rd_a_i      (issue_rs1_i),
    .rd_b_i      (issue_rs2_i),
    .rd_a_data_o (rs1_data),
    .rd_b_data_o (rs2_data),
    .wr_en_i     (wr_en),
    .wr_idx_i    (wr_idx),
    .wr_data_i   (wr_data)
  );

  alu_unit u_alu (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .start_i     (alu_start),
    .op_i        (ex_op),
    .rd_i        (ex_rd),
    .a_i         (ex_a),
    .b_i         (ex_b),
    .res_valid_o (alu_res_valid),
    .res_rd_o    (alu_res_rd),
    .res_data_o  (alu_res_data)
  );

  mul_pipe u_mul (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .start_i       (mul_start),
    .rd_i          (ex_rd),
    .a_i           (ex_a),
    .b_i           (ex_b),
    .stage4_busy_o (mul_stage4_busy),
    .res_valid_o   (mul_res_valid),
    .res_rd_o      (mul_res_rd),
    .res_data_o    (mul_res_data)
  );

  wb_stage u_wb (
    .clk_i       (clk_i),
    .alu_valid_i (alu_res_valid),
    .alu_rd_i    (alu_res_rd),
    .alu_data_i  (alu_res_data),
    .mul_valid_i (mul_res_valid),
    .mul_rd_i    (mul_res_rd),
    .mul_data_i  (mul_res_data),
    .wr_en_o     (wr_en),
    .wr_idx_o    (wr_idx),
    .wr_data_o   (wr_data),
    .wb_valid_o  (wb_valid_o),
    .wb_rd_o     (wb_rd_o),
    .wb_data_o   (wb_data_o)
  );

endmodule

`default_nettype wire

// File: test/tb_exu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_macros.svh"

module tb_exu;

  localparam int ISSUE_LIMIT = 64;
  localparam int DRAIN_LIMIT = 200;
  localparam int RANDOM_OPS  = 300;

  logic              clk_i;
  logic              rst_i;
  logic              issue_valid_i;
  logic              issue_ready_o;
  exu_pkg::op_e      issue_op_i;
  exu_pkg::reg_idx_t issue_rd_i;
  exu_pkg::reg_idx_t issue_rs1_i;
  exu_pkg::reg_idx_t issue_rs2_i;
  exu_pkg::data_t    issue_imm_i;
  logic              wb_valid_o;
  exu_pkg::reg_idx_t wb_rd_o;
  exu_pkg::data_t    wb_data_o;

  // Register values in program order, and the writes still to come
  exu_pkg::data_t model_regs [`EXU_NREGS];
  exu_pkg::data_t exp_data_q [`EXU_NREGS][$];
  int             exp_due_q  [`EXU_NREGS][$];

  int cycle;
  int data_errs;
  int timing_errs;
  int other_errs;
  int seed_val;

  exu_top dut0 (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .issue_valid_i (issue_valid_i),
    .issue_ready_o (issue_ready_o),
    .issue_op_i    (issue_op_i),
    .issue_rd_i    (issue_rd_i),
    .issue_rs1_i   (issue_rs1_i),
    .issue_rs2_i   (issue_rs2_i),
    .issue_imm_i   (issue_imm_i),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  // ============================================================
  // Reference model
  // ============================================================
  function automatic exu_pkg::data_t ref_result(input exu_pkg::op_e op,
                                                input exu_pkg::data_t a,
                                                input exu_pkg::data_t b,
                                                input exu_pkg::data_t imm);
    exu_pkg::data_t r;
    case (op)
      exu_pkg::OP_LI:  r = imm;
      exu_pkg::OP_ADD: r = a + b;
      exu_pkg::OP_SUB: r = a - b;
      exu_pkg::OP_AND: r = a & b;
      exu_pkg::OP_OR:  r = a | b;
      exu_pkg::OP_XOR: r = a ^ b;
      exu_pkg::OP_SLL: r = a << b[`EXU_SHAMT_W-1:0];
      exu_pkg::OP_MUL: r = a * b;
      default:         r = '0;
    endcase
    return r;
  endfunction

  function automatic int expected_left();
    int n;
    n = 0;
    for (int i = 0; i < `EXU_NREGS; i++) begin
      n += exp_data_q[i].size();
    end
    return n;
  endfunction

  // Sources are final at acceptance, so the model runs in issue order
  always @(posedge clk_i) begin : record_accept
    exu_pkg::data_t res;
    int             lat;
    if (rst_i && issue_valid_i && issue_ready_o) begin
      res = ref_result(issue_op_i, model_regs[issue_rs1_i], model_regs[issue_rs2_i],
                       issue_imm_i);
      lat = (issue_op_i == exu_pkg::OP_MUL) ? `EXU_MUL_STAGES : 1;
      if (issue_rd_i != '0) begin
        model_regs[issue_rd_i] = res;
        exp_data_q[issue_rd_i].push_back(res);
        exp_due_q[issue_rd_i].push_back(cycle + lat);
      end
    end
  end

  always @(posedge clk_i) begin : check_writeback
    exu_pkg::data_t exp_data;
    int             exp_due;
    if (rst_i && wb_valid_o) begin
      if (wb_rd_o == '0) begin
        other_errs++;
        $display("ERROR at %0t: a write to r0 appeared on the wb ports", $time);
      end else if (exp_data_q[wb_rd_o].size() == 0) begin
        other_errs++;
        $display("ERROR at %0t: unexpected writeback to r%0d", $time, wb_rd_o);
      end else begin
        exp_data = exp_data_q[wb_rd_o].pop_front();
        exp_due  = exp_due_q[wb_rd_o].pop_front();
        if (wb_data_o !== exp_data) begin
          data_errs++;
          $display("FAIL t=%0t wb_data_o r%0d exp=%h got=%h",
                   $time, wb_rd_o, exp_data, wb_data_o);
        end
        if (cycle != exp_due) begin
          timing_errs++;
          $display("FAIL t=%0t wb_valid_o cycle r%0d exp=%0d got=%0d",
                   $time, wb_rd_o, exp_due, cycle);
        end
      end
    end
  end

  // ============================================================
  // Stimulus helpers
  // ============================================================
  task automatic issue_op(input exu_pkg::op_e op, input int rd, input int rs1,
                          input int rs2, input exu_pkg::data_t imm, output int acc);
    int   waited;
    logic done;
    @(negedge clk_i);
    issue_valid_i = 1'b1;
    issue_op_i    = op;
    issue_rd_i    = exu_pkg::reg_idx_t'(rd);
    issue_rs1_i   = exu_pkg::reg_idx_t'(rs1);
    issue_rs2_i   = exu_pkg::reg_idx_t'(rs2);
    issue_imm_i   = imm;
    waited = 0;
    done   = 1'b0;
    while (!done && waited < ISSUE_LIMIT) begin
      @(posedge clk_i);
      done = issue_ready_o;
      waited++;
    end
    acc = cycle;
    if (!done) begin
      other_errs++;
      $display("ERROR at %0t: operation to r%0d was never accepted", $time, rd);
    end
  endtask

  task automatic go_idle();
    @(negedge clk_i);
    issue_valid_i = 1'b0;
  endtask

  task automatic drain();
    int waited;
    go_idle();
    waited = 0;
    while (expected_left() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (expected_left() != 0) begin
      other_errs++;
      $display("ERROR at %0t: %0d expected writebacks never arrived", $time, expected_left());
    end
  endtask

  task automatic check_accept(input string what, input int exp, input int got);
    if (got != exp) begin
      timing_errs++;
      $display("FAIL t=%0t %s exp=%0d got=%0d", $time, what, exp, got);
    end
  endtask

  // ============================================================
  // Test sequence
  // ============================================================
  initial begin : stimulus
    int acc;
    int base;
    seed_val      = $urandom(32'h2150d13d);
    cycle         = 0;
    data_errs     = 0;
    timing_errs   = 0;
    other_errs    = 0;
    rst_i         = 1'b0;
    issue_valid_i = 1'b0;
    issue_op_i    = exu_pkg::OP_LI;
    issue_rd_i    = '0;
    issue_rs1_i   = '0;
    issue_rs2_i   = '0;
    issue_imm_i   = '0;
    for (int i = 0; i < `EXU_NREGS; i++) begin
      model_regs[i] = '0;
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b1;
    @(negedge clk_i);
    if (issue_ready_o !== 1'b1) begin
      other_errs++;
      $display("FAIL t=%0t issue_ready_o exp=1 got=%b", $time, issue_ready_o);
    end
    if (wb_valid_o !== 1'b0) begin
      other_errs++;
      $display("FAIL t=%0t wb_valid_o exp=0 got=%b", $time, wb_valid_o);
    end

    // Load immediates, then every ALU operation
    for (int i = 1; i < 8; i++) begin
      issue_op(exu_pkg::OP_LI, i, 0, 0, $urandom, acc);
    end
    issue_op(exu_pkg::OP_ADD, 8, 1, 2, '0, acc);
    issue_op(exu_pkg::OP_SUB, 9, 3, 4, '0, acc);
    issue_op(exu_pkg::OP_AND, 10, 5, 6, '0, acc);
    issue_op(exu_pkg::OP_OR, 11, 7, 1, '0, acc);
    issue_op(exu_pkg::OP_XOR, 12, 2, 3, '0, acc);
    issue_op(exu_pkg::OP_SLL, 13, 4, 5, '0, acc);
    drain();

    // Independent multiplies, one per cycle
    issue_op(exu_pkg::OP_MUL, 14, 1, 2, '0, base);
    for (int k = 1; k < 5; k++) begin
      issue_op(exu_pkg::OP_MUL, 14 + k, 2 * k + 1, 2 * k + 2, '0, acc);
      check_accept("mul accept cycle", base + k, acc);
    end
    drain();

    // Source and destination hazards on pending results
    issue_op(exu_pkg::OP_MUL, 19, 11, 12, '0, base);
    issue_op(exu_pkg::OP_ADD, 20, 19, 1, '0, acc);
    check_accept("rs1 hazard accept cycle", base + `EXU_MUL_STAGES + 1, acc);
    base = acc;
    issue_op(exu_pkg::OP_LI, 20, 0, 0, 32'h0badcafe, acc);
    check_accept("rd hazard accept cycle", base + 2, acc);
    drain();

    // ALU held off while a multiply sits in stage four
    issue_op(exu_pkg::OP_MUL, 21, 2, 3, '0, base);
    issue_op(exu_pkg::OP_XOR, 22, 4, 5, '0, acc);
    issue_op(exu_pkg::OP_OR, 23, 6, 7, '0, acc);
    issue_op(exu_pkg::OP_AND, 24, 8, 9, '0, acc);
    check_accept("alu accept cycle", base + 3, acc);
    issue_op(exu_pkg::OP_SUB, 25, 10, 11, '0, acc);
    check_accept("stalled alu accept cycle", base + `EXU_MUL_STAGES, acc);
    drain();

    // r0 as destination, then as a source
    issue_op(exu_pkg::OP_ADD, 0, 1, 2, '0, acc);
    issue_op(exu_pkg::OP_MUL, 0, 3, 4, '0, acc);
    issue_op(exu_pkg::OP_LI, 0, 0, 0, 32'hffffffff, acc);
    issue_op(exu_pkg::OP_ADD, 26, 0, 5, '0, acc);
    drain();

    // Random stream with bubbles
    for (int n = 0; n < RANDOM_OPS; n++) begin
      if ($urandom_range(0, 3) == 0) begin
        go_idle();
      end
      issue_op(exu_pkg::op_e'($urandom_range(0, 7)), $urandom_range(0, 31),
               $urandom_range(0, 31), $urandom_range(0, 31), $urandom, acc);
    end
    drain();

    $display("Errors: data=%0d timing=%0d other=%0d", data_errs, timing_errs, other_errs);
    if (data_errs + timing_errs + other_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+common
common/exu_pkg.sv
design/issue_ctrl.sv
design/reg_bank.sv
exec/alu_unit.sv
exec/mul_pipe.sv
design/wb_stage.sv
design/exu_top.sv
test/tb_exu.sv

// File: Bender.yml
package:
  name: exu

sources:
  - include_dirs:
      - common
    files:
      - common/exu_pkg.sv
      - design/issue_ctrl.sv
      - design/reg_bank.sv
      - exec/alu_unit.sv
      - exec/mul_pipe.sv
      - design/wb_stage.sv
      - design/exu_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - test/tb_exu.sv
